/* compile.f */
verilog/core_pkg.sv
verilog/lsu_cmd_if.sv
verilog/fetch_unit.sv
verilog/reg_file.sv
verilog/exec_ctrl.sv
verilog/load_store_unit.sv
verilog/core_top.sv
testbench/core_chk.sv
testbench/tb_core.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and decide the result from the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_core -f compile.f -o vtb_core \
    && ./obj_dir/vtb_core +verilator+error+limit+10 > sim.log 2>&1 \
    || echo "build or simulation returned an error status"
cat sim.log 2>/dev/null
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "no pass message in sim.log"; exit 1; }

/* testbench/core_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module core_chk (
    input logic                        clk_i,
    input logic                        reset_i,
    input logic [core_pkg::XLEN-1:0]   imem_req_addr_i,
    input logic                        imem_req_valid_i,
    input logic                        imem_req_ready_i,
    input logic                        imem_rsp_ready_i,
    input logic [core_pkg::XLEN-1:0]   dmem_req_addr_i,
    input logic [core_pkg::XLEN-1:0]   dmem_req_wdata_i,
    input logic [core_pkg::MASK_W-1:0] dmem_req_mask_i,
    input logic                        dmem_req_write_i,
    input logic                        dmem_req_valid_i,
    input logic                        dmem_req_ready_i,
    input logic                        dmem_rsp_ready_i,
    input core_pkg::opc_e              opc_i,
    input core_pkg::ctrl_state_e       state_i
);
    import core_pkg::*;

    // failures seen so far, the testbench watches this count
    int fail_cnt = 0;

    idle_after_reset: assert property (@(posedge clk_i)
        reset_i |=> !imem_req_valid_i && !dmem_req_valid_i && !imem_rsp_ready_i && !dmem_rsp_ready_i)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("request valid or response ready active during or right after reset");
    end

    first_fetch_at_reset_pc: assert property (@(posedge clk_i)
        $fell(reset_i) |=> imem_req_valid_i && (imem_req_addr_i == RESET_PC))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("first instruction request missing or not at the reset pc");
    end

    imem_req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        imem_req_valid_i && !imem_req_ready_i |=> imem_req_valid_i && $stable(imem_req_addr_i))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("instruction request changed while stalled");
    end

    dmem_req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        dmem_req_valid_i && !dmem_req_ready_i |=> dmem_req_valid_i && $stable(dmem_req_addr_i)
            && $stable(dmem_req_wdata_i) && $stable(dmem_req_mask_i) && $stable(dmem_req_write_i))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("data request changed while stalled");
    end

    // reads come only from LW, and data requests only while in ST_MEM
    read_only_for_load: assert property (@(posedge clk_i) disable iff (reset_i)
        dmem_req_valid_i && !dmem_req_write_i |-> (opc_i == OPC_LOAD) && (state_i == ST_MEM))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("data read request raised outside a load");
    end

endmodule

bind core_top core_chk chk0 (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .imem_req_addr_i  (imem_req_addr_o),
    .imem_req_valid_i (imem_req_valid_o),
    .imem_req_ready_i (imem_req_ready_i),
    .imem_rsp_ready_i (imem_rsp_ready_o),
    .dmem_req_addr_i  (dmem_req_addr_o),
    .dmem_req_wdata_i (dmem_req_wdata_o),
    .dmem_req_mask_i  (dmem_req_mask_o),
    .dmem_req_write_i (dmem_req_write_o),
    .dmem_req_valid_i (dmem_req_valid_o),
    .dmem_req_ready_i (dmem_req_ready_i),
    .dmem_rsp_ready_i (dmem_rsp_ready_o),
    .opc_i            (u_exec.opc),
    .state_i          (u_exec.state_q)
);

`default_nettype wire

/* testbench/tb_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core;
    import core_pkg::*;

    localparam int              MEM_WORDS   = 256;
    localparam logic [XLEN-1:0] MARKER_ADDR = 32'h0000_01fc;
    localparam logic [XLEN-1:0] SPIN_PC     = 32'h0000_0048;
    // 27 fetches up to the marker store, each with room for long ready stalls
    localparam int RUN_INSNS       = 27;
    localparam int INSN_MAX_CYC    = 74;
    localparam int WATCHDOG_CYCLES = RUN_INSNS * INSN_MAX_CYC;

    logic              clk;
    logic              reset;
    logic [XLEN-1:0]   imem_req_addr;
    logic              imem_req_valid;
    logic              imem_req_ready;
    logic [XLEN-1:0]   imem_rsp_data;
    logic              imem_rsp_valid;
    logic              imem_rsp_ready;
    logic [XLEN-1:0]   dmem_req_addr;
    logic [XLEN-1:0]   dmem_req_wdata;
    logic [MASK_W-1:0] dmem_req_mask;
    logic              dmem_req_write;
    logic              dmem_req_valid;
    logic              dmem_req_ready;
    logic [XLEN-1:0]   dmem_rsp_data;
    logic              dmem_rsp_valid;
    logic              dmem_rsp_ready;

    logic [XLEN-1:0]   mem [MEM_WORDS];
    logic [XLEN-1:0]   exp_pc [$];
    logic [XLEN-1:0]   exp_st_addr [$];
    logic [XLEN-1:0]   exp_st_data [$];
    // pending read responses with the cycle they may be returned
    logic [XLEN-1:0]   iq_data [$];
    int                iq_due [$];
    logic [XLEN-1:0]   dq_data [$];
    int                dq_due [$];
    logic [31:0]       lcg_state = 32'd76506;
    int                cyc = 0;

    core_top dut0 (
        .clk_i            (clk),
        .reset_i          (reset),
        .imem_req_addr_o  (imem_req_addr),
        .imem_req_valid_o (imem_req_valid),
        .imem_req_ready_i (imem_req_ready),
        .imem_rsp_data_i  (imem_rsp_data),
        .imem_rsp_valid_i (imem_rsp_valid),
        .imem_rsp_ready_o (imem_rsp_ready),
        .dmem_req_addr_o  (dmem_req_addr),
        .dmem_req_wdata_o (dmem_req_wdata),
        .dmem_req_mask_o  (dmem_req_mask),
        .dmem_req_write_o (dmem_req_write),
        .dmem_req_valid_o (dmem_req_valid),
        .dmem_req_ready_i (dmem_req_ready),
        .dmem_rsp_data_i  (dmem_rsp_data),
        .dmem_rsp_valid_i (dmem_rsp_valid),
        .dmem_rsp_ready_o (dmem_rsp_ready)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // RV32I encodings of the kept instructions
    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OPC_IMM};
    endfunction

    function automatic logic [31:0] addsub(input logic sub, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        return {1'b0, sub, 5'b00000, rs2, rs1, 3'b000, rd, OPC_REG};
    endfunction

    function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, OPC_LOAD};
    endfunction

    function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                               input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic end_run();
        if (dut0.chk0.fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            abort_run("bound assertions failed during the run");
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hdead_0000 | 32'(i << 2);
        end
        mem[0]  = addi(5'd1, 5'd0, 12'd7);
        mem[1]  = addi(5'd2, 5'd0, 12'd5);
        mem[2]  = addsub(1'b0, 5'd3, 5'd1, 5'd2);
        mem[3]  = addsub(1'b1, 5'd4, 5'd1, 5'd2);
        mem[4]  = addi(5'd5, 5'd0, 12'd0);
        mem[5]  = addi(5'd6, 5'd0, 12'd5);
        // loop body at 0x18, bne jumps back by 4
        mem[6]  = addi(5'd5, 5'd5, 12'd1);
        mem[7]  = branch(3'b001, 5'd5, 5'd6, 13'h1ffc);
        mem[8]  = addi(5'd7, 5'd0, 12'h100);
        mem[9]  = store_word(5'd3, 5'd7, 12'd0);
        mem[10] = store_word(5'd4, 5'd7, 12'd4);
        mem[11] = store_word(5'd5, 5'd7, 12'd8);
        mem[12] = load_word(5'd8, 5'd7, 12'd0);
        mem[13] = addi(5'd8, 5'd8, 12'd1);
        mem[14] = store_word(5'd8, 5'd7, 12'd12);
        // 0xd0e does not fit a signed 12-bit immediate, so build it as 1671 + 1671
        mem[15] = addi(5'd9, 5'd0, 12'd1671);
        mem[16] = addsub(1'b0, 5'd9, 5'd9, 5'd9);
        mem[17] = store_word(5'd9, 5'd7, 12'h0fc);
        mem[18] = branch(3'b000, 5'd0, 5'd0, 13'd0);
    endtask

    task automatic set_expectations();
        for (int a = 0; a <= 'h14; a += 4) begin
            exp_pc.push_back(32'(a));
        end
        repeat (5) begin
            exp_pc.push_back(32'h18);
            exp_pc.push_back(32'h1c);
        end
        for (int a = 'h20; a <= 'h48; a += 4) begin
            exp_pc.push_back(32'(a));
        end
        exp_st_addr = '{32'h100, 32'h104, 32'h108, 32'h10c, MARKER_ADDR};
        exp_st_data = '{32'd12, 32'd2, 32'd5, 32'd13, 32'h0000_0d0e};
    endtask

    task automatic check_store();
        logic [XLEN-1:0] want_addr;
        logic [XLEN-1:0] want_data;
        if (exp_st_addr.size() == 0) begin
            abort_run("store seen after the last expected store");
        end else begin
            want_addr = exp_st_addr.pop_front();
            want_data = exp_st_data.pop_front();
            assert (dmem_req_addr == want_addr) else begin
                $display("ERR dmem_req_addr_o got 0x%08h exp 0x%08h", dmem_req_addr, want_addr);
                abort_run("store stream out of order");
            end
            assert (dmem_req_wdata == want_data) else begin
                $display("ERR dmem_req_wdata_o got 0x%08h exp 0x%08h", dmem_req_wdata, want_data);
                abort_run("store data wrong");
            end
            assert (dmem_req_mask == 4'hf) else begin
                $display("ERR dmem_req_mask_o got 0x%01h exp 0xf", dmem_req_mask);
                abort_run("store is not a full word");
            end
            if (want_addr == MARKER_ADDR) begin
                end_run();
            end
        end
    endtask

    // a valid response is held until the DUT takes it
    task automatic drive_responses();
        imem_rsp_valid = 1'b0;
        if (iq_due.size() > 0 && iq_due[0] <= cyc) begin
            imem_rsp_valid = 1'b1;
            imem_rsp_data  = iq_data[0];
            if (imem_rsp_ready) begin
                void'(iq_due.pop_front());
                void'(iq_data.pop_front());
            end
        end
        dmem_rsp_valid = 1'b0;
        if (dq_due.size() > 0 && dq_due[0] <= cyc) begin
            dmem_rsp_valid = 1'b1;
            dmem_rsp_data  = dq_data[0];
            if (dmem_rsp_ready) begin
                void'(dq_due.pop_front());
                void'(dq_data.pop_front());
            end
        end
    endtask

    task automatic serve_fetch(input logic [31:0] r);
        logic [XLEN-1:0] want;
        imem_req_ready = (r[17:16] != 2'b00);
        if (imem_req_valid && imem_req_ready) begin
            want = (exp_pc.size() > 0) ? exp_pc.pop_front() : SPIN_PC;
            assert (imem_req_addr == want) else begin
                $display("ERR imem_req_addr_o got 0x%08h exp 0x%08h", imem_req_addr, want);
                abort_run("instruction fetch left the expected program flow");
            end
            iq_data.push_back(mem[imem_req_addr[9:2]]);
            iq_due.push_back(cyc + 1 + int'(r[21:20]));
        end
    endtask

    task automatic serve_data(input logic [31:0] r);
        logic [7:0] idx;
        dmem_req_ready = (r[19:18] != 2'b00);
        if (dmem_req_valid && dmem_req_ready) begin
            idx = dmem_req_addr[9:2];
            if (dmem_req_addr >= 32'(MEM_WORDS * 4)) begin
                abort_run("data access outside the memory model");
            end else if (!dmem_req_write) begin
                dq_data.push_back(mem[idx]);
                dq_due.push_back(cyc + 1 + int'(r[23:22]));
            end else begin
                for (int b = 0; b < MASK_W; b++) begin
                    if (dmem_req_mask[b]) begin
                        mem[idx][8*b +: 8] = dmem_req_wdata[8*b +: 8];
                    end
                end
                check_store();
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

    // memory model, all DUT inputs change on the falling edge
    initial begin : mem_model
        logic [31:0] r;
        imem_req_ready = 1'b0;
        imem_rsp_data  = '0;
        imem_rsp_valid = 1'b0;
        dmem_req_ready = 1'b0;
        dmem_rsp_data  = '0;
        dmem_rsp_valid = 1'b0;
        load_program();
        set_expectations();
        forever begin
            @(negedge clk);
            cyc++;
            r = next_rand();
            if (dut0.chk0.fail_cnt != 0) begin
                abort_run("a bound assertion on the DUT failed");
            end else begin
                drive_responses();
                serve_fetch(r);
                serve_data(r);
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("timeout after %0d cycles without the marker store", WATCHDOG_CYCLES));
    end

endmodule

`default_nettype wire

/* verilog/core_pkg.sv */
`default_nettype none

package core_pkg;

    // data path and bus widths
    localparam int XLEN       = 32;
    localparam int MASK_W     = XLEN / 8;
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // instruction field positions
    localparam int OPC_W   = 7;
    localparam int F3_W    = 3;
    localparam int RD_LSB  = 7;
    localparam int F3_LSB  = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    // funct7 bit that turns ADD into SUB
    localparam int SUB_BIT = 30;

    // funct3 codes of the kept instructions
    localparam logic [F3_W-1:0] F3_ADD = 3'b000;
    localparam logic [F3_W-1:0] F3_BEQ = 3'b000;
    localparam logic [F3_W-1:0] F3_BNE = 3'b001;

    // supported major opcodes, anything else is a no-op
    typedef enum logic [OPC_W-1:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_IMM    = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_REG    = 7'b0110011,
        OPC_BRANCH = 7'b1100011
    } opc_e;

    // execute control sequence
    typedef enum logic [1:0] {
        ST_FETCH = 2'd0,
        ST_EXEC  = 2'd1,
        ST_MEM   = 2'd2,
        ST_WB    = 2'd3
    } ctrl_state_e;

endpackage

`default_nettype wire

/* verilog/core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  logic                        clk_i,
    input  logic                        reset_i,
    // instruction port
    output logic [core_pkg::XLEN-1:0]   imem_req_addr_o,
    output logic                        imem_req_valid_o,
    input  logic                        imem_req_ready_i,
    input  logic [core_pkg::XLEN-1:0]   imem_rsp_data_i,
    input  logic                        imem_rsp_valid_i,
    output logic                        imem_rsp_ready_o,
    // data port
    output logic [core_pkg::XLEN-1:0]   dmem_req_addr_o,
    output logic [core_pkg::XLEN-1:0]   dmem_req_wdata_o,
    output logic [core_pkg::MASK_W-1:0] dmem_req_mask_o,
    output logic                        dmem_req_write_o,
    output logic                        dmem_req_valid_o,
    input  logic                        dmem_req_ready_i,
    input  logic [core_pkg::XLEN-1:0]   dmem_rsp_data_i,
    input  logic                        dmem_rsp_valid_i,
    output logic                        dmem_rsp_ready_o
);
    import core_pkg::*;

    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       insn;
    logic                  insn_valid;
    logic                  fetch_go;
    logic [XLEN-1:0]       next_pc;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_we;
    logic [XLEN-1:0]       rd_wdata;
    logic [XLEN-1:0]       rdata1;
    logic [XLEN-1:0]       rdata2;

    lsu_cmd_if lsu_cmd ();

    fetch_unit u_fetch (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .fetch_go_i       (fetch_go),
        .next_pc_i        (next_pc),
        .imem_req_ready_i (imem_req_ready_i),
        .imem_rsp_data_i  (imem_rsp_data_i),
        .imem_rsp_valid_i (imem_rsp_valid_i),
        .imem_req_addr_o  (imem_req_addr_o),
        .imem_req_valid_o (imem_req_valid_o),
        .imem_rsp_ready_o (imem_rsp_ready_o),
        .pc_o             (pc),
        .insn_o           (insn),
        .insn_valid_o     (insn_valid)
    );

    reg_file u_regs (
        .clk_i    (clk_i),
        .rs1_i    (rs1),
        .rs2_i    (rs2),
        .we_i     (rd_we),
        .rd_i     (rd),
        .wdata_i  (rd_wdata),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    exec_ctrl u_exec (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .insn_i       (insn),
        .insn_valid_i (insn_valid),
        .pc_i         (pc),
        .rdata1_i     (rdata1),
        .rdata2_i     (rdata2),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .rd_we_o      (rd_we),
        .rd_o         (rd),
        .rd_wdata_o   (rd_wdata),
        .fetch_go_o   (fetch_go),
        .next_pc_o    (next_pc),
        .lsu          (lsu_cmd.ctrl)
    );

    load_store_unit u_lsu (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .dmem_req_ready_i (dmem_req_ready_i),
        .dmem_rsp_data_i  (dmem_rsp_data_i),
        .dmem_rsp_valid_i (dmem_rsp_valid_i),
        .dmem_req_addr_o  (dmem_req_addr_o),
        .dmem_req_wdata_o (dmem_req_wdata_o),
        .dmem_req_mask_o  (dmem_req_mask_o),
        .dmem_req_write_o (dmem_req_write_o),
        .dmem_req_valid_o (dmem_req_valid_o),
        .dmem_rsp_ready_o (dmem_rsp_ready_o),
        .cmd              (lsu_cmd.lsu)
    );

endmodule

`default_nettype wire

/* verilog/exec_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  logic [core_pkg::XLEN-1:0]       insn_i,
    input  logic                            insn_valid_i,
    input  logic [core_pkg::XLEN-1:0]       pc_i,
    input  logic [core_pkg::XLEN-1:0]       rdata1_i,
    input  logic [core_pkg::XLEN-1:0]       rdata2_i,
    output logic [core_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [core_pkg::REG_ADDR_W-1:0] rs2_o,
    output logic                            rd_we_o,
    output logic [core_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [core_pkg::XLEN-1:0]       rd_wdata_o,
    output logic                            fetch_go_o,
    output logic [core_pkg::XLEN-1:0]       next_pc_o,
    lsu_cmd_if.ctrl                         lsu
);
    import core_pkg::*;

    ctrl_state_e     state_q;
    opc_e            opc;
    logic [F3_W-1:0] funct3;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] alu_result;
    logic            alu_we;
    logic            branch_taken;
    logic            is_mem;
    logic [XLEN-1:0] pc_plus4;

    // decode
    assign opc    = opc_e'(insn_i[OPC_W-1:0]);
    assign funct3 = insn_i[F3_LSB +: F3_W];
    assign rs1_o  = insn_i[RS1_LSB +: REG_ADDR_W];
    assign rs2_o  = insn_i[RS2_LSB +: REG_ADDR_W];
    assign rd_o   = insn_i[RD_LSB +: REG_ADDR_W];
    assign is_mem = (opc == OPC_LOAD) || (opc == OPC_STORE);

    assign imm_i = {{20{insn_i[31]}}, insn_i[31:20]};
    assign imm_s = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
    assign imm_b = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};

    // add/sub and branch compare
    always_comb begin
        alu_result   = rdata1_i + imm_i;
        alu_we       = 1'b0;
        branch_taken = 1'b0;
        case (opc)
            OPC_IMM: begin
                alu_we = (funct3 == F3_ADD);
            end
            OPC_REG: begin
                alu_we     = (funct3 == F3_ADD);
                alu_result = insn_i[SUB_BIT] ? (rdata1_i - rdata2_i) : (rdata1_i + rdata2_i);
            end
            OPC_BRANCH: begin
                if (funct3 == F3_BEQ) begin
                    branch_taken = (rdata1_i == rdata2_i);
                end else if (funct3 == F3_BNE) begin
                    branch_taken = (rdata1_i != rdata2_i);
                end
            end
            default: begin
                alu_we = 1'b0;
            end
        endcase
    end

    assign pc_plus4  = pc_i + 32'd4;
    assign next_pc_o = branch_taken ? (pc_i + imm_b) : pc_plus4;

    // load/store command, address is rs1 plus I or S immediate
    assign lsu.start = (state_q == ST_EXEC) && is_mem;
    assign lsu.write = (opc == OPC_STORE);
    assign lsu.addr  = rdata1_i + ((opc == OPC_STORE) ? imm_s : imm_i);
    assign lsu.wdata = rdata2_i;

    // ALU results retire in ST_EXEC, load data in ST_WB
    assign rd_we_o    = ((state_q == ST_EXEC) && alu_we) ||
                        ((state_q == ST_WB) && (opc == OPC_LOAD));
    assign rd_wdata_o = (state_q == ST_WB) ? lsu.rdata : alu_result;
    assign fetch_go_o = ((state_q == ST_EXEC) && !is_mem) || (state_q == ST_WB);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ST_FETCH;
        end else begin
            case (state_q)
                ST_FETCH: begin
                    if (insn_valid_i) begin
                        state_q <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    state_q <= is_mem ? ST_MEM : ST_FETCH;
                end
                ST_MEM: begin
                    if (lsu.done) begin
                        state_q <= ST_WB;
                    end
                end
                default: begin
                    state_q <= ST_FETCH;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      fetch_go_i,
    input  logic [core_pkg::XLEN-1:0] next_pc_i,
    input  logic                      imem_req_ready_i,
    input  logic [core_pkg::XLEN-1:0] imem_rsp_data_i,
    input  logic                      imem_rsp_valid_i,
    output logic [core_pkg::XLEN-1:0] imem_req_addr_o,
    output logic                      imem_req_valid_o,
    output logic                      imem_rsp_ready_o,
    output logic [core_pkg::XLEN-1:0] pc_o,
    output logic [core_pkg::XLEN-1:0] insn_o,
    output logic                      insn_valid_o
);
    import core_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] insn_q;
    // first fetch after reset needs no go pulse
    logic            boot_q;
    logic            req_q;
    logic            wait_q;
    logic            insn_valid_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q         <= RESET_PC;
            boot_q       <= 1'b1;
            req_q        <= 1'b0;
            wait_q       <= 1'b0;
            insn_valid_q <= 1'b0;
        end else begin
            insn_valid_q <= 1'b0;
            if (boot_q || fetch_go_i) begin
                boot_q <= 1'b0;
                req_q  <= 1'b1;
            end
            if (fetch_go_i) begin
                pc_q <= next_pc_i;
            end
            // request accepted, now wait for the word
            if (req_q && imem_req_ready_i) begin
                req_q  <= 1'b0;
                wait_q <= 1'b1;
            end
            if (wait_q && imem_rsp_valid_i) begin
                wait_q       <= 1'b0;
                insn_valid_q <= 1'b1;
            end
        end
    end

    // instruction word holds until the next response
    always_ff @(posedge clk_i) begin
        if (wait_q && imem_rsp_valid_i) begin
            insn_q <= imem_rsp_data_i;
        end
    end

    assign imem_req_addr_o  = pc_q;
    assign imem_req_valid_o = req_q;
    assign imem_rsp_ready_o = wait_q;
    assign pc_o             = pc_q;
    assign insn_o           = insn_q;
    assign insn_valid_o     = insn_valid_q;

endmodule

`default_nettype wire

/* verilog/load_store_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        dmem_req_ready_i,
    input  logic [core_pkg::XLEN-1:0]   dmem_rsp_data_i,
    input  logic                        dmem_rsp_valid_i,
    output logic [core_pkg::XLEN-1:0]   dmem_req_addr_o,
    output logic [core_pkg::XLEN-1:0]   dmem_req_wdata_o,
    output logic [core_pkg::MASK_W-1:0] dmem_req_mask_o,
    output logic                        dmem_req_write_o,
    output logic                        dmem_req_valid_o,
    output logic                        dmem_rsp_ready_o,
    lsu_cmd_if.lsu                      cmd
);
    import core_pkg::*;

    logic [XLEN-1:0] addr_q;
    logic [XLEN-1:0] wdata_q;
    logic [XLEN-1:0] rdata_q;
    logic            write_q;
    logic            req_q;
    logic            wait_q;
    logic            done_q;

    // command and load data payload
    always_ff @(posedge clk_i) begin
        if (cmd.start) begin
            addr_q  <= cmd.addr;
            wdata_q <= cmd.wdata;
            write_q <= cmd.write;
        end
        if (wait_q && dmem_rsp_valid_i) begin
            rdata_q <= dmem_rsp_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            req_q  <= 1'b0;
            wait_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (cmd.start) begin
                req_q <= 1'b1;
            end
            if (req_q && dmem_req_ready_i) begin
                req_q <= 1'b0;
                // a store is finished once accepted
                if (write_q) begin
                    done_q <= 1'b1;
                end else begin
                    wait_q <= 1'b1;
                end
            end
            if (wait_q && dmem_rsp_valid_i) begin
                wait_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    assign dmem_req_addr_o  = addr_q;
    assign dmem_req_wdata_o = wdata_q;
    // word accesses only
    assign dmem_req_mask_o  = {MASK_W{1'b1}};
    assign dmem_req_write_o = write_q;
    assign dmem_req_valid_o = req_q;
    assign dmem_rsp_ready_o = wait_q;
    assign cmd.done         = done_q;
    assign cmd.rdata        = rdata_q;

endmodule

`default_nettype wire

/* verilog/lsu_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface lsu_cmd_if;
    import core_pkg::*;

    // command side, one-cycle start pulse
    logic            start;
    logic            write;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;

    // completion side, one-cycle done pulse
    logic            done;
    logic [XLEN-1:0] rdata;

    modport ctrl (
        output start, write, addr, wdata,
        input  done, rdata
    );

    modport lsu (
        input  start, write, addr, wdata,
        output done, rdata
    );

endinterface

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                            clk_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic                            we_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [core_pkg::XLEN-1:0]       wdata_i,
    output logic [core_pkg::XLEN-1:0]       rdata1_o,
    output logic [core_pkg::XLEN-1:0]       rdata2_o
);
    import core_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    // x0 is never written
    always_ff @(posedge clk_i) begin
        if (we_i && (rd_i != '0)) begin
            regs[rd_i] <= wdata_i;
        end
    end

    assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire
